//--- rtl/pi_bus_config.svh
// Build constants of the PI bus subsystem.
// Queue depths must be powers of two.
`ifndef PI_BUS_CONFIG_SVH
`define PI_BUS_CONFIG_SVH

`define PI_CMD_DEPTH     4
`define PI_RSP_DEPTH     4
`define PI_WAIT_STATES   1
`define PI_GNT_DELAY     2
`define PI_TIMEOUT       8
`define PI_MEM_WORDS     16

// opcodes, only single word is used
`define PI_OPC_NOP       4'b0000
`define PI_OPC_WORD      4'b0001

// address bits 29..28
`define PI_REGION_MEM    2'd0
`define PI_REGION_RETRY  2'd1
`define PI_REGION_ERR    2'd2
`define PI_REGION_SILENT 2'd3

`endif

//--- rtl/pi_bus_pkg.sv
// Shared PI bus types. Only single-word transfers exist, so no size field is carried.
// RDM is accepted as a synonym of RDY everywhere.
package pi_bus_pkg;

   // acknowledge codes driven by the slave
   typedef enum logic [2:0] {
      ACK_IDL = 3'd0,
      ACK_RDY = 3'd1,
      ACK_RDM = 3'd2,
      ACK_WAT = 3'd3,
      ACK_ERR = 3'd4,
      ACK_RTR = 3'd5
   } pi_ack_e;

   typedef enum logic [1:0] {
      ST_OK   = 2'd0,
      ST_ERR  = 2'd1,
      ST_TOUT = 2'd2
   } pi_status_e;

   // one host command
   typedef struct packed {
      logic        write;
      logic        lock;   // next command shares the tenure
      logic [29:0] addr;   // word address
      logic [31:0] wdata;
   } pi_cmd_t;

   typedef struct packed {
      pi_status_e  status;
      logic [31:0] rdata;  // zero on writes and failures
   } pi_rsp_t;

endpackage

//--- rtl/pi_bus_if.sv
// PI bus signals of the single master system.
// opc other than NOP marks an address phase.
`timescale 1ns/1ns

interface pi_bus_if;
   logic                req;
   logic                gnt;
   logic [29:0]         addr;
   logic [3:0]          opc;
   logic                lock;
   logic                read;
   logic [31:0]         wdata;
   logic [31:0]         rdata;
   pi_bus_pkg::pi_ack_e ack;
   logic                tout;

   modport master (
      output req, addr, opc, lock, read, wdata,
      input  gnt, rdata, ack, tout
   );

   modport slave (
      input  addr, opc, read, wdata, tout,
      output ack, rdata
   );

   modport watchdog (
      input  req, opc, ack,
      output gnt, tout
   );
endinterface

//--- rtl/pi_credit_fifo.sv
// FIFO with credit handling on both sides.
// DEPTH must be a power of two; a push into a full queue is dropped.
// credit_out pulses one cycle after each pop.
`timescale 1ns/1ns

module pi_credit_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int  DEPTH     = 4
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t pop_data,
   output logic     not_empty,
   output logic     full,
   input  logic     credit_in,
   output logic     credit_out,
   output logic     send
);
   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t      store [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic [7:0]    credits;   // downstream credits held
   logic          do_push;
   logic          do_pop;

   assign not_empty = (count != '0);
   assign full      = (count == (AW+1)'(DEPTH));
   assign send      = not_empty && (credits != 8'd0);
   assign do_push   = push && !full;
   assign do_pop    = (pop || send) && not_empty;
   assign pop_data  = store[rd_ptr];

   always_ff @(posedge clk)
      if (do_push)
         store[wr_ptr] <= push_data;

   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         credits    <= 8'd0;
         credit_out <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         count      <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
         credits    <= credits + 8'(credit_in) - 8'(send);
         credit_out <= do_pop;
      end

endmodule

//--- rtl/pi_master_fsm.sv
// PI bus master. At most two commands are owed a response at any time,
// so a locked pair overlaps its second address with the first data phase.
// RTR or timeout drops an already issued follow-up address, which is sent again later.
`timescale 1ns/1ns
`include "pi_bus_config.svh"

module pi_master_fsm (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cmd_avail,
   input  pi_bus_pkg::pi_cmd_t   cmd,
   output logic                  cmd_pop,
   input  logic                  rsp_full,
   output logic                  rsp_push,
   output pi_bus_pkg::pi_rsp_t   rsp,
   pi_bus_if.master              bus
);
   import pi_bus_pkg::*;

   typedef enum logic [2:0] {IDLE, REQ, ADDR, ADDR_DATA, DATA, RETRY} state_e;

   state_e   state;
   pi_cmd_t  cur;         // command of the current data phase
   pi_cmd_t  nxt;         // follow-up of a locked command
   logic     has_nxt;
   logic [1:0] owed;      // popped commands without a pushed response
   pi_rsp_t  hold [2];
   logic [1:0] hold_v;
   pi_rsp_t  new_rsp;
   pi_cmd_t  issue_cmd;
   logic     in_data, phase_end, finish, advance;
   logic     pop_ok, lock_pop, resend, grant_go, issue, slot;

   always_comb
   begin
      in_data   = (state == DATA) || (state == ADDR_DATA);
      phase_end = bus.tout || (bus.ack inside {ACK_RDY, ACK_RDM, ACK_ERR, ACK_RTR});
      finish    = in_data && phase_end && (bus.tout || bus.ack != ACK_RTR);
      advance   = finish && has_nxt;
      pop_ok    = cmd_avail && !rsp_full && (owed < 2'd2);
      lock_pop  = pop_ok && cur.lock && !has_nxt &&
                  ((state == ADDR) || (state == DATA && !phase_end));
      cmd_pop   = (state == IDLE && pop_ok) || lock_pop;
      resend    = (state == ADDR) && has_nxt;
      grant_go  = (state == REQ || state == RETRY) && bus.gnt;
      issue     = grant_go || resend || lock_pop;
      issue_cmd = grant_go ? cur : (resend ? nxt : cmd);

      if (bus.tout)
         new_rsp.status = ST_TOUT;
      else if (bus.ack == ACK_ERR)
         new_rsp.status = ST_ERR;
      else
         new_rsp.status = ST_OK;
      new_rsp.rdata = (new_rsp.status == ST_OK && !cur.write) ? bus.rdata : 32'd0;
   end

   assign rsp_push  = hold_v[0] && !rsp_full;
   assign rsp       = hold[0];
   assign slot      = rsp_push ? hold_v[1] : hold_v[0];  // first free after shift
   assign bus.wdata = cur.wdata;

   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         state   <= IDLE;
         has_nxt <= 1'b0;
         owed    <= 2'd0;
         hold_v  <= 2'b00;
         bus.req <= 1'b0;
         bus.opc <= `PI_OPC_NOP;
      end
      else
      begin
         bus.opc <= issue ? `PI_OPC_WORD : `PI_OPC_NOP;
         owed    <= owed + 2'(cmd_pop) - 2'(rsp_push);
         if (rsp_push)
         begin
            hold_v[0] <= hold_v[1];
            hold_v[1] <= 1'b0;
         end
         if (finish)
            hold_v[slot] <= 1'b1;

         case (state)
            IDLE:
               if (cmd_pop)
               begin
                  bus.req <= 1'b1;
                  state   <= REQ;
               end
            REQ, RETRY:
               if (bus.gnt)
               begin
                  bus.req <= 1'b0;
                  state   <= ADDR;
               end
            ADDR:
            begin
               if (lock_pop)
                  has_nxt <= 1'b1;
               state <= issue ? ADDR_DATA : DATA;
            end
            default:     // DATA, ADDR_DATA
               if (bus.tout)
               begin
                  has_nxt <= 1'b0;
                  bus.req <= has_nxt;   // follow-up needs its own tenure
                  state   <= has_nxt ? REQ : IDLE;
               end
               else if (bus.ack == ACK_RTR)
               begin
                  bus.req <= 1'b1;
                  state   <= RETRY;
               end
               else if (phase_end)
               begin
                  has_nxt <= 1'b0;
                  state   <= has_nxt ? DATA : IDLE;
               end
               else if (lock_pop)
               begin
                  has_nxt <= 1'b1;
                  state   <= ADDR_DATA;
               end
               else
                  state <= DATA;
         endcase
      end

   // payload, no reset
   always_ff @(posedge clk)
   begin
      if (state == IDLE && cmd_pop)
         cur <= cmd;
      if (lock_pop)
         nxt <= cmd;
      if (advance)
         cur <= nxt;
      if (issue)
      begin
         bus.addr <= issue_cmd.addr;
         bus.read <= !issue_cmd.write;
         bus.lock <= issue_cmd.lock;
      end
      if (rsp_push)
         hold[0] <= hold[1];
      if (finish)
         hold[slot] <= new_rsp;
   end

endmodule

//--- rtl/pi_bus_watchdog.sv
// Grant and timeout source for a single master.
// Up to two address phases may be outstanding; RTR or timeout clears them all.
`timescale 1ns/1ns
`include "pi_bus_config.svh"

module pi_bus_watchdog (
   input  logic        clk,
   input  logic        rst_n,
   pi_bus_if.watchdog  bus
);
   import pi_bus_pkg::*;

   logic [7:0] cnt;      // request cycles or idle ack cycles
   logic [1:0] outst;    // addresses awaiting completion
   logic       cpl;

   assign cpl = bus.ack inside {ACK_RDY, ACK_RDM, ACK_ERR};

   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         cnt      <= 8'd0;
         outst    <= 2'd0;
         bus.gnt  <= 1'b0;
         bus.tout <= 1'b0;
      end
      else
      begin
         if (bus.tout || bus.ack == ACK_RTR)
            outst <= 2'd0;
         else
            outst <= outst + 2'(bus.opc != `PI_OPC_NOP) - 2'(cpl);

         if (bus.req)
         begin
            cnt      <= cnt + 8'd1;
            bus.gnt  <= !bus.gnt && (cnt == 8'(`PI_GNT_DELAY - 1));
            bus.tout <= 1'b0;
         end
         else if (outst != 2'd0 && bus.ack == ACK_IDL && !bus.tout)
         begin
            cnt      <= cnt + 8'd1;
            bus.tout <= (cnt == 8'(`PI_TIMEOUT - 1));
         end
         else
         begin
            cnt      <= 8'd0;   // restart
            bus.gnt  <= 1'b0;
            bus.tout <= 1'b0;
         end
      end

endmodule

//--- rtl/pi_mem_slave.sv
// Word memory slave, indexed by the low address bits in every region.
// Memory clears on reset. Retry region answers RTR once per access.
// Holds one pending address behind the active data phase.
`timescale 1ns/1ns
`include "pi_bus_config.svh"

module pi_mem_slave (
   input  logic     clk,
   input  logic     rst_n,
   pi_bus_if.slave  bus
);
   import pi_bus_pkg::*;

   localparam int IW = $clog2(`PI_MEM_WORDS);

   logic [31:0]              mem [`PI_MEM_WORDS];
   logic [`PI_MEM_WORDS-1:0] rtr_seen;   // retry already given
   logic [29:0]              s_addr, p_addr;
   logic                     s_read, p_read;
   logic                     s_act, p_val;
   logic [3:0]               wcnt;
   logic [1:0]               region;
   logic [IW-1:0]            idx;
   logic                     cpl;
   logic                     mem_ready;

   assign region    = s_addr[29:28];
   assign idx       = s_addr[IW-1:0];
   assign mem_ready = (wcnt >= 4'(`PI_WAIT_STATES));
   assign cpl       = (bus.ack == ACK_RDY) || (bus.ack == ACK_ERR);
   assign bus.rdata = (s_act && s_read) ? mem[idx] : 32'd0;

   always_comb
      if (!s_act)
         bus.ack = ACK_IDL;
      else
         case (region)
            `PI_REGION_MEM:   bus.ack = mem_ready ? ACK_RDY : ACK_WAT;
            `PI_REGION_RETRY: bus.ack = !rtr_seen[idx] ? ACK_RTR :
                                        (mem_ready ? ACK_RDY : ACK_WAT);
            `PI_REGION_ERR:   bus.ack = ACK_ERR;
            default:          bus.ack = ACK_IDL;   // silent
         endcase

   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         for (int i = 0; i < `PI_MEM_WORDS; i++)
            mem[i] <= 32'd0;
         rtr_seen <= '0;
         s_addr   <= 30'd0;
         p_addr   <= 30'd0;
         s_read   <= 1'b0;
         p_read   <= 1'b0;
         s_act    <= 1'b0;
         p_val    <= 1'b0;
         wcnt     <= 4'd0;
      end
      else if (bus.tout || bus.ack == ACK_RTR)
      begin
         s_act <= 1'b0;   // master restarts everything
         p_val <= 1'b0;
         wcnt  <= 4'd0;
         if (bus.ack == ACK_RTR)
            rtr_seen[idx] <= 1'b1;
      end
      else
      begin
         if (bus.ack == ACK_WAT)
            wcnt <= wcnt + 4'd1;
         if (cpl)
         begin
            wcnt <= 4'd0;
            if (region == `PI_REGION_RETRY)
               rtr_seen[idx] <= 1'b0;
            if (bus.ack == ACK_RDY && !s_read)
               mem[idx] <= bus.wdata;
         end
         if (bus.opc != `PI_OPC_NOP)
         begin
            if (!s_act || cpl)
            begin
               s_act  <= 1'b1;
               s_addr <= bus.addr;
               s_read <= bus.read;
            end
            else
            begin
               p_val  <= 1'b1;
               p_addr <= bus.addr;
               p_read <= bus.read;
            end
         end
         else if (cpl)
         begin
            s_act  <= p_val;
            s_addr <= p_addr;
            s_read <= p_read;
            p_val  <= 1'b0;
         end
      end

endmodule

//--- rtl/pi_bus_top.sv
// PI bus subsystem with credit-controlled host queues.
// Host holds PI_CMD_DEPTH command credits after reset; response credits start at zero.
`timescale 1ns/1ns
`include "pi_bus_config.svh"

module pi_bus_top (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                cmd_valid,
   input  pi_bus_pkg::pi_cmd_t cmd_data,
   output logic                cmd_credit,
   input  logic                rsp_credit,
   output logic                rsp_valid,
   output pi_bus_pkg::pi_rsp_t rsp_data
);
   import pi_bus_pkg::*;

   pi_cmd_t cmd_head;
   logic    cmd_avail;
   logic    cmd_pop;
   pi_rsp_t rsp_new;
   logic    rsp_push;
   logic    rsp_full;

   pi_bus_if bus_if ();

   pi_credit_fifo #(.payload_t(pi_cmd_t), .DEPTH(`PI_CMD_DEPTH)) cmd_q (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (cmd_valid),
      .push_data  (cmd_data),
      .pop        (cmd_pop),
      .pop_data   (cmd_head),
      .not_empty  (cmd_avail),
      .full       (),
      .credit_in  (1'b0),
      .credit_out (cmd_credit),
      .send       ()
   );

   pi_credit_fifo #(.payload_t(pi_rsp_t), .DEPTH(`PI_RSP_DEPTH)) rsp_q (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (rsp_push),
      .push_data  (rsp_new),
      .pop        (1'b0),       // drained by send
      .pop_data   (rsp_data),
      .not_empty  (),
      .full       (rsp_full),
      .credit_in  (rsp_credit),
      .credit_out (),
      .send       (rsp_valid)
   );

   pi_master_fsm master_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_avail (cmd_avail),
      .cmd       (cmd_head),
      .cmd_pop   (cmd_pop),
      .rsp_full  (rsp_full),
      .rsp_push  (rsp_push),
      .rsp       (rsp_new),
      .bus       (bus_if.master)
   );

   pi_bus_watchdog watchdog_i (.clk(clk), .rst_n(rst_n), .bus(bus_if.watchdog));

   pi_mem_slave slave_i (.clk(clk), .rst_n(rst_n), .bus(bus_if.slave));

endmodule

//--- bench/pi_bus_tb.sv
// Self-checking testbench for the PI bus subsystem.
// Expected responses come from a host-side memory model that shares the low
// address bits across all regions, as the slave does. Tasks start 1 ns after a rising edge.
`timescale 1ns/1ns
`include "pi_bus_config.svh"

module pi_bus_tb;
   import pi_bus_pkg::*;

   localparam int WAIT_LIMIT = 400;   // cycles per wait loop
   localparam int IW = $clog2(`PI_MEM_WORDS);

   logic        clk;
   logic        rst_n;
   logic        cmd_valid;
   pi_cmd_t     cmd_data;
   logic        cmd_credit;
   logic        rsp_credit;
   logic        rsp_valid;
   pi_rsp_t     rsp_data;

   logic [31:0] ref_mem [`PI_MEM_WORDS];
   pi_rsp_t     exp_q [$];
   pi_rsp_t     head;
   int          credits;    // host command credits
   int          pushed;
   int          returned;
   int          owed_rsp;   // response credits held back
   int          checks;
   int          errors;
   int          err_mark;
   logic        withhold;
   logic        hung;       // a wait ran out
   logic        wr;
   logic [29:0] a;

   pi_bus_top pi_bus_top_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd_data   (cmd_data),
      .cmd_credit (cmd_credit),
      .rsp_credit (rsp_credit),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data)
   );

   always #20 clk = ~clk;

   assert property (@(negedge clk) disable iff (!rst_n) withhold |-> !rsp_valid)
      else
      begin
         $display("rsp_valid was raised while no response credit was given");
         errors++;
      end

   assert property (@(negedge clk) disable iff (!rst_n) returned <= pushed)
      else
      begin
         $display("more command credits came back than commands were pushed");
         errors++;
      end

   // outputs are stable at the falling edge
   always @(negedge clk)
   begin
      if (rst_n && cmd_credit)
      begin
         credits++;
         returned++;
      end
      if (rst_n && rsp_valid)
      begin
         if (exp_q.size() == 0)
         begin
            $display("a response arrived with no command outstanding");
            errors++;
         end
         else
         begin
            head = exp_q.pop_front();
            checks++;
            assert (rsp_data.status == head.status)
               else
               begin
                  $display("[FAIL] rsp_data.status exp=%h got=%h", head.status, rsp_data.status);
                  errors++;
               end
            assert (rsp_data.rdata == head.rdata)
               else
               begin
                  $display("[FAIL] rsp_data.rdata exp=%h got=%h", head.rdata, rsp_data.rdata);
                  errors++;
               end
         end
      end
   end

   function automatic pi_rsp_t model_rsp(input logic w, input logic [29:0] addr,
                                         input logic [31:0] d);
      pi_rsp_t r;
      r.rdata = 32'd0;
      case (addr[29:28])
         `PI_REGION_ERR:    r.status = ST_ERR;
         `PI_REGION_SILENT: r.status = ST_TOUT;
         default:
         begin
            r.status = ST_OK;   // retry is hidden from the host
            if (w)
               ref_mem[addr[IW-1:0]] = d;
            else
               r.rdata = ref_mem[addr[IW-1:0]];
         end
      endcase
      return r;
   endfunction

   task automatic note_timeout(input string why);
      $display("timeout: %s", why);
      errors++;
      hung = 1'b1;
   endtask

   task automatic send_cmd(input logic w, input logic lk, input logic [29:0] addr,
                           input logic [31:0] d);
      int n;
      n = 0;
      while (credits == 0 && !hung && n < WAIT_LIMIT)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (credits == 0 && !hung)
         note_timeout("no command credit came back");
      if (credits != 0)
      begin
         exp_q.push_back(model_rsp(w, addr, d));
         credits--;
         pushed++;
         if (withhold)
            owed_rsp++;
         cmd_valid  = 1'b1;
         cmd_data   = '{write: w, lock: lk, addr: addr, wdata: d};
         rsp_credit = !withhold;   // one response credit per command
         @(posedge clk);
         #1;
         cmd_valid  = 1'b0;
         rsp_credit = 1'b0;
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && !hung && n < WAIT_LIMIT)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (exp_q.size() != 0 && !hung)
         note_timeout("expected responses did not arrive");
   endtask

   task automatic end_test(input string name);
      wait_drain();
      $display("test %s: %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   initial
   begin
      void'($urandom(73956));
      clk        = 1'b0;
      rst_n      = 1'b0;
      cmd_valid  = 1'b0;
      cmd_data   = '0;
      rsp_credit = 1'b0;
      withhold   = 1'b0;
      hung       = 1'b0;
      credits    = `PI_CMD_DEPTH;
      pushed     = 0;
      returned   = 0;
      owed_rsp   = 0;
      checks     = 0;
      errors     = 0;
      err_mark   = 0;
      for (int i = 0; i < `PI_MEM_WORDS; i++)
         ref_mem[i] = 32'd0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;

      send_cmd(1'b1, 1'b0, 30'h0000_0003, 32'hdead_beef);
      send_cmd(1'b0, 1'b0, 30'h0000_0003, 32'd0);
      send_cmd(1'b0, 1'b0, 30'h0000_0009, 32'd0);   // never written
      end_test("plain write and read");

      send_cmd(1'b1, 1'b0, 30'h2000_0005, 32'h1234_5678);
      send_cmd(1'b0, 1'b0, 30'h0000_0003, 32'd0);
      end_test("error region");

      send_cmd(1'b0, 1'b0, 30'h3000_0006, 32'd0);
      send_cmd(1'b1, 1'b0, 30'h0000_0007, 32'h0bad_cafe);
      send_cmd(1'b0, 1'b0, 30'h0000_0007, 32'd0);
      end_test("silent region");

      send_cmd(1'b1, 1'b0, 30'h1000_000a, 32'h5a5a_a5a5);
      send_cmd(1'b0, 1'b0, 30'h1000_000a, 32'd0);
      end_test("retry region");

      for (int i = 0; i < 8; i++)
      begin
         wr = 1'($urandom);
         a  = {2'd0, 28'($urandom)};
         send_cmd(wr, i != 7, a, $urandom);   // last one closes the tenure
      end
      end_test("locked sequence");

      withhold = 1'b1;
      for (int i = 0; i < 6; i++)
         send_cmd(i % 2 == 0, 1'b0, 30'(12 + i / 2), 32'hc0de_0000 + 32'(i));
      repeat (30) @(posedge clk);   // watch rsp_valid stay low
      #1;
      withhold = 1'b0;
      while (owed_rsp > 0)
      begin
         rsp_credit = 1'b1;
         owed_rsp--;
         @(posedge clk);
         #1;
      end
      rsp_credit = 1'b0;
      end_test("credit flow");

      $display("checks=%0d errors=%0d", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+rtl
rtl/pi_bus_pkg.sv
rtl/pi_bus_if.sv
rtl/pi_credit_fifo.sv
rtl/pi_master_fsm.sv
rtl/pi_bus_watchdog.sv
rtl/pi_mem_slave.sv
rtl/pi_bus_top.sv
bench/pi_bus_tb.sv

//--- Makefile
# Verilator build and run of the PI bus testbench
TOP = pi_bus_tb

all: run

obj_dir/V$(TOP): verilog.f $(wildcard rtl/*) $(wildcard bench/*)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f verilog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ns \
		--top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
